/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_lcd_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* files.f */
lcd_cmd_pkg.sv
lcd_char_pkg.sv
lcd_pulse_timer.sv
lcd_instructions.sv
lcd_message_rom.sv
lcd_render_ctrl.sv
lcd_top.sv
tb_lcd_top.sv

/* lcd_char_pkg.sv */
package lcd_char_pkg;

    // codes 6 and 7 are unused and show the recording text
    typedef enum logic [2:0] {
        MODE_INIT       = 3'd0,
        MODE_STOP       = 3'd1,
        MODE_PLAY_PAUSE = 3'd2,
        MODE_REC_PAUSE  = 3'd3,
        MODE_PLAYING    = 3'd4,
        MODE_RECORDING  = 3'd5
    } disp_mode_t;

    localparam logic [7:0] CH_SPACE = 8'h20;

    // 32 bytes each, position 0 in the top byte
    // text starts at column 3 of row 0, row 1 stays blank
    localparam logic [255:0] msg_table [6] = '{
        {{3{CH_SPACE}}, "Initializing", {17{CH_SPACE}}},
        {{3{CH_SPACE}}, "Stop",         {25{CH_SPACE}}},
        {{3{CH_SPACE}}, "Play Pause",   {19{CH_SPACE}}},
        {{3{CH_SPACE}}, "Record Pause", {17{CH_SPACE}}},
        {{3{CH_SPACE}}, "Playing",      {22{CH_SPACE}}},
        {{3{CH_SPACE}}, "Recording",    {20{CH_SPACE}}}
    };

    function automatic logic [7:0] msg_char(
        input logic [2:0] mode,
        input logic [4:0] pos
    );
        logic [2:0] sel;
        sel = (mode > MODE_RECORDING) ? MODE_RECORDING : mode;   // fold 6 and 7
        return msg_table[sel][8*(31 - pos) +: 8];
    endfunction

endpackage

/* lcd_cmd_pkg.sv */
package lcd_cmd_pkg;

    localparam int WAIT_W     = 16;   // width of any wait count
    localparam int INIT_COUNT = 5;

    // init types come first, in the order they go out on the bus
    typedef enum logic [2:0] {
        INST_FUNC_SET = 3'd0,
        INST_DISP_OFF = 3'd1,
        INST_CLEAR    = 3'd2,
        INST_ENTRY    = 3'd3,
        INST_DISP_ON  = 3'd4,
        INST_SET_ADDR = 3'd5
    } inst_type_t;

    localparam logic [7:0] OP_FUNC_SET = 8'h38;   // 8-bit bus, 2 lines, 5x8 font
    localparam logic [7:0] OP_DISP_OFF = 8'h08;
    localparam logic [7:0] OP_CLEAR    = 8'h01;   // needs the long wait
    localparam logic [7:0] OP_ENTRY    = 8'h06;   // increment, no shift
    localparam logic [7:0] OP_DISP_ON  = 8'h0C;   // cursor and blink off
    localparam logic [7:0] OP_SET_ADDR = 8'h80;   // DDRAM address in [6:0]

    localparam logic [6:0] ROW0_ADDR = 7'h00;
    localparam logic [6:0] ROW1_ADDR = 7'h40;

    typedef enum logic [2:0] {
        ST_BEGIN    = 3'd0,
        ST_INIT     = 3'd1,
        ST_IDLE     = 3'd2,
        ST_SET_ADDR = 3'd3,
        ST_FETCH    = 3'd4,
        ST_WRITE    = 3'd5
    } ctrl_state_t;

endpackage

/* lcd_instructions.sv */
`timescale 1ns/1ps

module lcd_instructions #(
    parameter int SHORT_WAIT = 8,
    parameter int LONG_WAIT  = 40
) (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    input  logic                           i_start,
    input  lcd_cmd_pkg::inst_type_t        i_type,
    input  logic [6:0]                     i_address,
    output logic [7:0]                     o_data,
    output logic [lcd_cmd_pkg::WAIT_W-1:0] o_wait,
    output logic                           o_tmr_start
);
    import lcd_cmd_pkg::*;

    logic [7:0]        opcode;
    logic [WAIT_W-1:0] wait_len;

    always_comb begin
        case (i_type)
            INST_FUNC_SET: opcode = OP_FUNC_SET;
            INST_DISP_OFF: opcode = OP_DISP_OFF;
            INST_CLEAR:    opcode = OP_CLEAR;
            INST_ENTRY:    opcode = OP_ENTRY;
            INST_DISP_ON:  opcode = OP_DISP_ON;
            INST_SET_ADDR: opcode = OP_SET_ADDR | {1'b0, i_address};
            default:       opcode = OP_DISP_OFF;   // harmless, blanks the display
        endcase
    end

    // clear rewrites all of DDRAM and needs much longer
    assign wait_len = (i_type == INST_CLEAR) ? WAIT_W'(LONG_WAIT) : WAIT_W'(SHORT_WAIT);

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            o_tmr_start <= 1'b0;
            o_data      <= 8'h00;
            o_wait      <= '0;
        end else begin
            o_tmr_start <= i_start;   // one cycle behind the request
            if (i_start) begin
                o_data <= opcode;
                o_wait <= wait_len;
            end
        end
    end

    a_type_valid: assert property (@(posedge i_clk) disable iff (i_rst_n)
        i_start |-> i_type inside {INST_FUNC_SET, INST_DISP_OFF, INST_CLEAR,
                                   INST_ENTRY, INST_DISP_ON, INST_SET_ADDR});

endmodule

/* lcd_message_rom.sv */
`timescale 1ns/1ps

module lcd_message_rom (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  lcd_char_pkg::disp_mode_t i_mode,
    input  logic [4:0]               i_index,
    output logic [7:0]               o_char
);
    import lcd_char_pkg::*;

    // one cycle of read latency, the controller spends it in ST_FETCH
    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            o_char <= CH_SPACE;
        end else begin
            o_char <= msg_char(i_mode, i_index);   // codes past MODE_RECORDING fold onto it
        end
    end

endmodule

/* lcd_pulse_timer.sv */
`timescale 1ns/1ps

module lcd_pulse_timer #(
    parameter int SETUP_CYCLES = 2,
    parameter int EN_CYCLES    = 4
) (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    input  logic                           i_start,
    input  logic [lcd_cmd_pkg::WAIT_W-1:0] i_wait,
    output logic                           o_lcd_en,
    output logic                           o_done
);
    import lcd_cmd_pkg::*;

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_SETUP,
        PH_EN,
        PH_WAIT
    } phase_t;

    phase_t            phase;
    logic [WAIT_W-1:0] cnt;        // cycles left in the current phase
    logic [WAIT_W-1:0] wait_len;

    assign o_lcd_en = (phase == PH_EN);
    assign o_done   = (phase == PH_WAIT) && (cnt == '0);

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            phase    <= PH_IDLE;
            cnt      <= '0;
            wait_len <= '0;
        end else begin
            case (phase)
                PH_IDLE: begin
                    if (i_start) begin
                        wait_len <= i_wait;
                        // start cycle already counts as the first setup cycle
                        if (SETUP_CYCLES > 1) begin
                            phase <= PH_SETUP;
                            cnt   <= WAIT_W'(SETUP_CYCLES - 2);
                        end else begin
                            phase <= PH_EN;
                            cnt   <= WAIT_W'(EN_CYCLES - 1);
                        end
                    end
                end
                PH_SETUP: begin
                    if (cnt == '0) begin
                        phase <= PH_EN;
                        cnt   <= WAIT_W'(EN_CYCLES - 1);
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                PH_EN: begin
                    if (cnt == '0) begin
                        phase <= PH_WAIT;
                        cnt   <= wait_len;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: begin
                    if (cnt == '0) begin
                        phase <= PH_IDLE;   // o_done seen this cycle
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
            endcase
        end
    end

    // the controller must wait for o_done before the next bus cycle
    a_no_overlap: assert property (@(posedge i_clk) disable iff (i_rst_n)
        i_start |-> phase == PH_IDLE);

endmodule

/* lcd_render_ctrl.sv */
`timescale 1ns/1ps

module lcd_render_ctrl #(
    parameter int WRITE_WAIT = 6
) (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    input  logic                           i_start,
    input  logic [2:0]                     i_mode,
    input  logic [7:0]                     i_inst_data,
    input  logic [lcd_cmd_pkg::WAIT_W-1:0] i_inst_wait,
    input  logic                           i_inst_tmr_start,
    input  logic [7:0]                     i_char,
    input  logic                           i_tmr_done,
    output logic                           o_inst_start,
    output lcd_cmd_pkg::inst_type_t        o_inst_type,
    output logic [6:0]                     o_address,
    output lcd_char_pkg::disp_mode_t       o_rom_mode,
    output logic [4:0]                     o_rom_index,
    output logic                           o_tmr_start,
    output logic [lcd_cmd_pkg::WAIT_W-1:0] o_tmr_wait,
    output logic [7:0]                     o_lcd_data,
    output logic                           o_lcd_rs,
    output logic                           o_init_done,
    output logic                           o_render_done
);
    import lcd_cmd_pkg::*;
    import lcd_char_pkg::*;

    ctrl_state_t state;
    logic [2:0]  init_idx;
    logic [4:0]  char_cnt;   // 0..15 row 0, 16..31 row 1
    logic        wr_start;
    logic        is_write;

    // bus source: ROM byte during a write, instruction encoder otherwise
    assign is_write    = (state == ST_WRITE);
    assign o_lcd_rs    = is_write;
    assign o_lcd_data  = is_write ? i_char : i_inst_data;
    assign o_tmr_start = is_write ? wr_start : i_inst_tmr_start;
    assign o_tmr_wait  = is_write ? WAIT_W'(WRITE_WAIT) : i_inst_wait;
    assign o_rom_index = char_cnt;

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            state         <= ST_BEGIN;
            init_idx      <= '0;
            char_cnt      <= '0;
            wr_start      <= 1'b0;
            o_inst_start  <= 1'b0;
            o_inst_type   <= INST_FUNC_SET;
            o_address     <= ROW0_ADDR;
            o_rom_mode    <= MODE_INIT;
            o_init_done   <= 1'b0;
            o_render_done <= 1'b0;
        end else begin
            o_inst_start <= 1'b0;
            wr_start     <= 1'b0;
            case (state)
                ST_BEGIN: begin
                    o_inst_start <= 1'b1;
                    o_inst_type  <= INST_FUNC_SET;
                    init_idx     <= '0;
                    state        <= ST_INIT;
                end
                ST_INIT: begin
                    if (i_tmr_done) begin
                        if (init_idx == 3'(INIT_COUNT - 1)) begin
                            o_init_done <= 1'b1;
                            state       <= ST_IDLE;
                        end else begin
                            o_inst_start <= 1'b1;
                            o_inst_type  <= inst_type_t'(init_idx + 3'd1);   // next init type
                            init_idx     <= init_idx + 3'd1;
                        end
                    end
                end
                ST_IDLE: begin
                    if (i_start) begin
                        o_rom_mode    <= disp_mode_t'(i_mode);   // held for the whole render
                        o_render_done <= 1'b0;
                        char_cnt      <= '0;
                        o_inst_start  <= 1'b1;
                        o_inst_type   <= INST_SET_ADDR;
                        o_address     <= ROW0_ADDR;
                        state         <= ST_SET_ADDR;
                    end
                end
                ST_SET_ADDR: begin
                    if (i_tmr_done) begin
                        state <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    wr_start <= 1'b1;   // ROM byte is valid next cycle
                    state    <= ST_WRITE;
                end
                ST_WRITE: begin
                    if (i_tmr_done) begin
                        char_cnt <= char_cnt + 5'd1;
                        if (char_cnt == 5'd31) begin
                            o_render_done <= 1'b1;
                            state         <= ST_IDLE;
                        end else if (char_cnt == 5'd15) begin
                            o_inst_start <= 1'b1;   // jump to row 1
                            o_inst_type  <= INST_SET_ADDR;
                            o_address    <= ROW1_ADDR;
                            state        <= ST_SET_ADDR;
                        end else begin
                            state <= ST_FETCH;
                        end
                    end
                end
                default: state <= ST_BEGIN;
            endcase
        end
    end

    // data write only, and RS with its byte held until the timer finishes
    a_rs_write: assert property (@(posedge i_clk) disable iff (i_rst_n)
        o_lcd_rs && !i_tmr_done |=> state == ST_WRITE && o_lcd_rs && $stable(o_lcd_data));

endmodule

/* lcd_top.sv */
`timescale 1ns/1ps

module lcd_top #(
    parameter int SETUP_CYCLES = 2,
    parameter int EN_CYCLES    = 4,
    parameter int SHORT_WAIT   = 8,
    parameter int LONG_WAIT    = 40,
    parameter int WRITE_WAIT   = 6
) (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_start,
    input  logic [2:0] i_mode,
    output logic [7:0] o_lcd_data,
    output logic       o_lcd_en,
    output logic       o_lcd_rs,
    output logic       o_lcd_rw,
    output logic       o_init_done,
    output logic       o_render_done
);
    import lcd_cmd_pkg::*;
    import lcd_char_pkg::*;

    logic              inst_start;
    inst_type_t        inst_type;
    logic [6:0]        address;
    logic [7:0]        inst_data;
    logic [WAIT_W-1:0] inst_wait;
    logic              inst_tmr_start;
    disp_mode_t        rom_mode;
    logic [4:0]        rom_index;
    logic [7:0]        rom_char;
    logic              tmr_start;
    logic [WAIT_W-1:0] tmr_wait;
    logic              tmr_done;

    assign o_lcd_rw = 1'b0;   // write only, no busy-flag reads

    lcd_render_ctrl #(
        .WRITE_WAIT(WRITE_WAIT)
    ) u_ctrl (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_start         (i_start),
        .i_mode          (i_mode),
        .i_inst_data     (inst_data),
        .i_inst_wait     (inst_wait),
        .i_inst_tmr_start(inst_tmr_start),
        .i_char          (rom_char),
        .i_tmr_done      (tmr_done),
        .o_inst_start    (inst_start),
        .o_inst_type     (inst_type),
        .o_address       (address),
        .o_rom_mode      (rom_mode),
        .o_rom_index     (rom_index),
        .o_tmr_start     (tmr_start),
        .o_tmr_wait      (tmr_wait),
        .o_lcd_data      (o_lcd_data),
        .o_lcd_rs        (o_lcd_rs),
        .o_init_done     (o_init_done),
        .o_render_done   (o_render_done)
    );

    lcd_instructions #(
        .SHORT_WAIT(SHORT_WAIT),
        .LONG_WAIT (LONG_WAIT)
    ) u_inst (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_start    (inst_start),
        .i_type     (inst_type),
        .i_address  (address),
        .o_data     (inst_data),
        .o_wait     (inst_wait),
        .o_tmr_start(inst_tmr_start)
    );

    lcd_message_rom u_rom (
        .i_clk  (i_clk),
        .i_rst_n(i_rst_n),
        .i_mode (rom_mode),
        .i_index(rom_index),
        .o_char (rom_char)
    );

    lcd_pulse_timer #(
        .SETUP_CYCLES(SETUP_CYCLES),
        .EN_CYCLES   (EN_CYCLES)
    ) u_timer (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_start (tmr_start),
        .i_wait  (tmr_wait),
        .o_lcd_en(o_lcd_en),
        .o_done  (tmr_done)
    );

endmodule

/* tb_lcd_top.sv */
`timescale 1ns/1ps

module tb_lcd_top;
    import lcd_cmd_pkg::*;
    import lcd_char_pkg::*;

    localparam int          CLK_NS       = 20;
    localparam int          SETUP_CYCLES = 2;
    localparam int          EN_CYCLES    = 4;
    localparam int          SHORT_WAIT   = 8;
    localparam int          LONG_WAIT    = 40;
    localparam int          WRITE_WAIT   = 6;
    localparam logic [31:0] SEED         = 32'h73a7_22f0;
    localparam int          RENDERS      = 12;
    localparam int          STREAM_LEN   = 34;   // two addresses, 32 characters

    // slowest ordinary bus cycle plus register and fetch overhead
    localparam int BUS_CYC     = SETUP_CYCLES + EN_CYCLES + SHORT_WAIT + 3;
    localparam int RENDER_CYC  = STREAM_LEN * BUS_CYC;
    localparam int INIT_CYC    = INIT_COUNT * (SETUP_CYCLES + EN_CYCLES + LONG_WAIT + 3);
    localparam int WATCHDOG_NS = (40 * RENDER_CYC + INIT_CYC + 100) * CLK_NS;

    logic       clk;
    logic       rst_n;
    logic       start;
    logic [2:0] mode_sel;
    logic [7:0] lcd_data;
    logic       lcd_en;
    logic       lcd_rs;
    logic       lcd_rw;
    logic       init_done;
    logic       render_done;

    logic [8:0]  last_got;     // {rs, data} of the latest strobe
    logic [8:0]  last_exp;
    logic        last_stray;
    logic [8:0]  strobe_q[$];
    int          strobe_n;
    int          render_pos;   // strobes seen in the current render
    int          value_errs;
    int          other_errs;
    logic        busy;
    logic [2:0]  exp_mode;
    logic [31:0] rnd;

    lcd_top #(
        .SETUP_CYCLES(SETUP_CYCLES),
        .EN_CYCLES   (EN_CYCLES),
        .SHORT_WAIT  (SHORT_WAIT),
        .LONG_WAIT   (LONG_WAIT),
        .WRITE_WAIT  (WRITE_WAIT)
    ) u_dut (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_start      (start),
        .i_mode       (mode_sel),
        .o_lcd_data   (lcd_data),
        .o_lcd_en     (lcd_en),
        .o_lcd_rs     (lcd_rs),
        .o_lcd_rw     (lcd_rw),
        .o_init_done  (init_done),
        .o_render_done(render_done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    function automatic logic [31:0] next_random(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [7:0] init_opcode(input int k);
        case (k)
            0:       return OP_FUNC_SET;
            1:       return OP_DISP_OFF;
            2:       return OP_CLEAR;
            3:       return OP_ENTRY;
            default: return OP_DISP_ON;
        endcase
    endfunction

    function automatic logic [8:0] render_byte(input logic [2:0] m, input int pos);
        logic [2:0] shown;
        shown = (m > 3'd5) ? 3'd5 : m;   // 5 to 7 all show the recording text
        if (pos == 0) begin
            return {1'b0, 8'h80};
        end else if (pos == 17) begin
            return {1'b0, 8'hC0};
        end else if (pos < 17) begin
            return {1'b1, msg_char(shown, 5'(pos - 1))};
        end else begin
            return {1'b1, msg_char(shown, 5'(pos - 2))};
        end
    endfunction

    // strobe monitor and expected-value tracker
    always @(negedge lcd_en) begin
        if (rst_n === 1'b0) begin
            last_got = {lcd_rs, lcd_data};
            if (strobe_n < INIT_COUNT) begin
                last_exp   = {1'b0, init_opcode(strobe_n)};
                last_stray = 1'b0;
            end else if (busy && render_pos < STREAM_LEN) begin
                last_exp   = render_byte(exp_mode, render_pos);
                last_stray = 1'b0;
                render_pos = render_pos + 1;
            end else begin
                last_exp   = last_got;
                last_stray = 1'b1;
            end
            strobe_q.push_back(last_got);
            strobe_n = strobe_n + 1;
        end
    end

    always @(posedge render_done) begin
        busy = 1'b0;
    end

    a_strobe_value: assert property (@(posedge clk) disable iff (rst_n)
        strobe_n != $past(strobe_n) |-> last_got == last_exp)
    else begin
        value_errs++;
        $display("FAIL t=%0t strobe %0d expected rs/data %h got %h",
                 $time, strobe_n - 1, last_exp, last_got);
    end

    a_no_stray: assert property (@(posedge clk) disable iff (rst_n)
        strobe_n != $past(strobe_n) |-> !last_stray)
    else begin
        other_errs++;
        $display("Unexpected bus write at %0t, no render was in progress", $time);
    end

    a_bus_stable: assert property (@(posedge clk) disable iff (rst_n)
        lcd_en |-> $stable(lcd_data) && $stable(lcd_rs))
    else begin
        value_errs++;
        $display("FAIL t=%0t bus changed while enable high, data %h rs %b",
                 $time, lcd_data, lcd_rs);
    end

    a_rw_low: assert property (@(posedge clk) lcd_rw == 1'b0)
    else begin
        value_errs++;
        $display("FAIL t=%0t rw expected 0 got %b", $time, lcd_rw);
    end

    a_init_rise: assert property (@(posedge clk) disable iff (rst_n)
        $rose(init_done) |-> strobe_n == INIT_COUNT)
    else begin
        other_errs++;
        $display("Init done rose after %0d bus writes instead of five", strobe_n);
    end

    a_init_hold: assert property (@(posedge clk) disable iff (rst_n)
        init_done |=> init_done)
    else begin
        other_errs++;
        $display("Init done dropped again at %0t", $time);
    end

    // busy already drops on the rising edge itself
    a_render_len: assert property (@(posedge clk) disable iff (rst_n)
        $rose(render_done) |-> $past(busy) && render_pos == STREAM_LEN)
    else begin
        other_errs++;
        $display("Render done rose after %0d of 34 bus writes", render_pos);
    end

    task automatic send_start(input logic [2:0] m);
        @(posedge clk);
        #2;
        mode_sel = m;
        start    = 1'b1;
        if (init_done && !busy) begin   // controller sits in idle
            busy       = 1'b1;
            exp_mode   = m;
            render_pos = 0;
        end
        @(posedge clk);
        #2;
        start = 1'b0;
    endtask

    task automatic run_render(input logic [2:0] m);
        int gap;
        int limit;
        send_start(m);
        rnd = next_random(rnd);
        gap = 5 + int'(rnd[5:0]);
        repeat (gap) @(posedge clk);
        #2;
        mode_sel = rnd[10:8];       // must not reach this render
        send_start(rnd[13:11]);     // dropped, render in progress
        limit = 0;
        while (busy && limit < 2 * RENDER_CYC) begin
            @(posedge clk);
            limit++;
        end
        if (busy) begin
            other_errs++;
            $display("Render in mode %0d did not finish", m);
            busy = 1'b0;
        end
    endtask

    initial begin
        logic [2:0] k;
        logic [2:0] m;
        int         limit;
        start      = 1'b0;
        mode_sel   = 3'd0;
        rst_n      = 1'b1;
        busy       = 1'b0;
        exp_mode   = 3'd0;
        strobe_n   = 0;
        render_pos = 0;
        value_errs = 0;
        other_errs = 0;
        last_got   = '0;
        last_exp   = '0;
        last_stray = 1'b0;
        rnd        = SEED;
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b0;

        send_start(3'd2);   // early starts, init still running
        repeat (10) @(posedge clk);
        send_start(3'd4);

        limit = 0;
        while (!init_done && limit < 2 * INIT_CYC) begin
            @(posedge clk);
            limit++;
        end
        if (!init_done) begin
            other_errs++;
            $display("Init done never rose after reset");
        end else begin
            rnd = next_random(rnd);
            k   = rnd[2:0];
            for (int n = 0; n < RENDERS; n++) begin
                rnd = next_random(rnd);
                m   = (n < 8) ? (3'(n) ^ k) : rnd[4:2];   // first eight hit every code
                run_render(m);
                repeat (3) @(posedge clk);
            end
        end
        repeat (50) @(posedge clk);   // room for any late strobe

        $display("strobes: %0d, value errors: %0d, other errors: %0d",
                 strobe_q.size(), value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout, the run did not finish within %0d ns", WATCHDOG_NS);
        $display("strobes: %0d, value errors: %0d, other errors: %0d",
                 strobe_q.size(), value_errs, other_errs);
        $display("Test failed");
        $finish;
    end

endmodule
